// File: logic/host_fifo_pkg.sv
/*
 * shared types for the host-to-device streaming channel:
 * beat, channel, block slot, beat index and block count types,
 * plus the default buffer and output FIFO sizes
 */

`default_nettype none

package host_fifo_pkg;

   typedef logic [63:0] data_t;    // one completion or output beat
   typedef logic [3:0]  chan_t;    // channel number, upper tag nibble
   typedef logic [3:0]  block_t;   // block slot, lower tag nibble
   typedef logic [5:0]  index_t;   // beat within a 64 beat block
   typedef logic [22:0] count_t;   // completed blocks, 512 bytes each

   // eight 512 byte blocks in the reorder buffer by default
   localparam int DEF_BLOCK_LOG2 = 3;
   // sixteen entry output FIFO by default
   localparam int DEF_DEPTH_LOG2 = 4;

endpackage : host_fifo_pkg

`default_nettype wire

// File: logic/cpl_if.sv
/*
 * completion beat bus from the receiver into the reorder buffer,
 * no back-pressure: a valid beat is always written that cycle
 */

`default_nettype none

interface cpl_if import host_fifo_pkg::*; ();

   logic   valid;   // beat present this cycle
   block_t block;   // destination block slot
   index_t index;   // beat position inside the block
   data_t  data;    // payload
   logic   last;    // beat 63, closes the block

   // receiver side drives every field
   modport rx  (output valid, block, index, data, last);
   // reorder buffer side only listens
   modport rob (input  valid, block, index, data, last);

endinterface : cpl_if

`default_nettype wire

// File: logic/cpl_receiver.sv
/*
 * completion receiver: keeps only beats for this channel,
 * registers them onto the completion bus with a last flag,
 * and counts finished blocks into the byte-count status word
 */

`default_nettype none

module cpl_receiver import host_fifo_pkg::*; (
   input  wire logic   i_clock,
   input  wire logic   i_reset,
   input  wire chan_t  i_chan,        // channel this receiver answers to
   input  wire logic   i_cpl_valid,
   input  wire logic [7:0] i_cpl_tag, // channel nibble and block nibble
   input  wire index_t i_cpl_index,
   input  wire data_t  i_cpl_data,
   cpl_if.rx           cpl,
   output logic [31:0] o_status       // bytes completed, 512 byte granularity
);

   logic   match;       // beat belongs to this channel
   logic   match_last;  // and it is the final beat of its block
   count_t blocks_done;

   assign match      = i_cpl_valid && (i_cpl_tag[7:4] == i_chan);
   assign match_last = match && (&i_cpl_index); // index 63
   assign o_status   = {blocks_done, 9'd0};     // count times 512

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         cpl.valid <= 1'b0;
         cpl.last  <= 1'b0;
      end else begin
         cpl.valid <= match;
         cpl.last  <= match_last;
      end
   end

   // payload follows the strobe, nothing to clear
   always_ff @(posedge i_clock) begin
      cpl.block <= block_t'(i_cpl_tag[3:0]);
      cpl.index <= i_cpl_index;
      cpl.data  <= i_cpl_data;
   end

   // counts off the registered last, so it lines up with the filled flag
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         blocks_done <= '0;
      end else if (cpl.valid && cpl.last) begin
         blocks_done <= blocks_done + count_t'(1);
      end
   end

endmodule : cpl_receiver

`default_nettype wire

// File: logic/read_requester.sv
/*
 * block read requester: sequential tags, a window of outstanding
 * blocks bounded by drain credits, and a short holdoff per request
 */

`default_nettype none

module read_requester import host_fifo_pkg::*; #(
   parameter int BLOCK_LOG2 = DEF_BLOCK_LOG2
) (
   input  wire logic i_clock,
   input  wire logic i_reset,
   input  wire logic i_rr_ready,   // upstream takes the request
   input  wire logic i_drained,    // one pulse per block read out
   output logic      o_rr_valid,
   output block_t    o_rr_tag
);

   localparam int NUM_BLOCKS = 1 << BLOCK_LOG2;

   logic [BLOCK_LOG2-1:0] p_request;    // next block to ask for
   logic [BLOCK_LOG2-1:0] p_drained;    // blocks handed back by the buffer
   logic [BLOCK_LOG2-1:0] outstanding;  // requested and not yet drained
   logic [1:0]            holdoff;      // cycles left before the next request
   logic                  xfer;

   assign outstanding = p_request - p_drained; // wraps cleanly mod NUM_BLOCKS
   // two slots held back so a late block never lands on one still draining
   assign o_rr_valid  = (holdoff == 2'd0) && (outstanding < BLOCK_LOG2'(NUM_BLOCKS - 2));
   assign o_rr_tag    = block_t'(p_request);
   assign xfer        = o_rr_valid && i_rr_ready;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         p_request <= '0;
         p_drained <= '0;
         holdoff   <= 2'd0;
      end else begin
         if (xfer) begin
            p_request <= p_request + 1'b1;
            holdoff   <= 2'd3;           // three idle cycles after a request
         end else if (holdoff != 2'd0) begin
            holdoff   <= holdoff - 2'd1;
         end
         if (i_drained) begin
            p_drained <= p_drained + 1'b1; // credit returns a slot
         end
      end
   end

endmodule : read_requester

`default_nettype wire

// File: logic/reorder_buffer.sv
/*
 * reorder buffer: block memory written at completion order,
 * per-block filled flags, block write pointer and beat read pointer
 * that hand beats to the output FIFO in request order
 */

`default_nettype none

module reorder_buffer import host_fifo_pkg::*; #(
   parameter int BLOCK_LOG2 = DEF_BLOCK_LOG2
) (
   input  wire logic i_clock,
   input  wire logic i_reset,
   cpl_if.rob        cpl,
   input  wire logic i_almost_full, // output FIFO has three or fewer free entries
   output logic      o_push,        // beat into the output FIFO
   output data_t     o_push_data,
   output logic      o_drained      // last beat of a block was read out
);

   localparam int NUM_BLOCKS = 1 << BLOCK_LOG2;
   localparam int ADDR_W     = BLOCK_LOG2 + 6;   // block slot then beat index

   data_t                 mem [NUM_BLOCKS * 64];
   logic [NUM_BLOCKS-1:0] filled;     // block has received its last beat
   logic [BLOCK_LOG2-1:0] p_write;    // oldest block not yet released for reading
   logic [ADDR_W-1:0]     p_read;     // next beat to read
   logic [ADDR_W-1:0]     w_addr;
   logic                  advance;    // block at the write pointer is complete
   logic                  rd_issue;   // read one beat this cycle
   logic                  rd_valid;   // memory output stage holds a beat
   data_t                 rd_data;

   assign w_addr  = {cpl.block[BLOCK_LOG2-1:0], cpl.index};
   assign advance = filled[p_write];
   // readable while reads trail released blocks and the FIFO has headroom
   assign rd_issue = (p_read[ADDR_W-1:6] != p_write) && !i_almost_full;

   // block ram, one write port from completions and one read port to the FIFO
   always_ff @(posedge i_clock) begin
      if (cpl.valid) begin
         mem[w_addr] <= cpl.data;
      end
      rd_data <= mem[p_read];
   end

   // completion order is arbitrary, so each slot tracks its own state
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         filled <= '0;
      end else begin
         for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (cpl.valid && cpl.last && (cpl.block[BLOCK_LOG2-1:0] == BLOCK_LOG2'(b))) begin
               filled[b] <= 1'b1;
            end else if (advance && (p_write == BLOCK_LOG2'(b))) begin
               filled[b] <= 1'b0;   // consumed as the write pointer moves past
            end
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         p_write   <= '0;
         p_read    <= '0;
         rd_valid  <= 1'b0;
         o_push    <= 1'b0;
         o_drained <= 1'b0;
      end else begin
         if (advance) begin
            p_write <= p_write + 1'b1;   // blocks are released strictly in tag order
         end
         if (rd_issue) begin
            p_read <= p_read + 1'b1;
         end
         rd_valid  <= rd_issue;          // memory stage
         o_push    <= rd_valid;          // output register stage
         o_drained <= rd_issue && (&p_read[5:0]); // beat 63 leaves the slot free
      end
   end

   // second pipeline stage, data only
   always_ff @(posedge i_clock) begin
      o_push_data <= rd_data;
   end

endmodule : reorder_buffer

`default_nettype wire

// File: logic/stream_fifo.sv
/*
 * single-clock first-word-fall-through output FIFO,
 * occupancy count and almost-full flag for drain control
 */

`default_nettype none

module stream_fifo import host_fifo_pkg::*; #(
   parameter int DEPTH_LOG2 = DEF_DEPTH_LOG2
) (
   input  wire logic  i_clock,
   input  wire logic  i_reset,
   input  wire logic  i_push,       // writer honours almost-full, so never overflows
   input  wire data_t i_push_data,
   output logic       o_almost_full,
   input  wire logic  i_read,       // pop, taken only while valid
   output data_t      o_read_data,
   output logic       o_read_valid
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   data_t                 mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;   // one extra bit so full is distinct from empty
   logic                  pop;

   assign pop          = i_read && o_read_valid;
   assign o_read_valid = (count != '0);
   assign o_read_data  = mem[rd_ptr];   // head word is always on the output
   // three free entries cover the beats already in the buffer pipeline
   assign o_almost_full = (count >= (DEPTH_LOG2 + 1)'(DEPTH - 3));

   always_ff @(posedge i_clock) begin
      if (i_push) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // push and pop together leave the count unchanged
         count <= count + {{DEPTH_LOG2{1'b0}}, i_push} - {{DEPTH_LOG2{1'b0}}, pop};
      end
   end

endmodule : stream_fifo

`default_nettype wire

// File: logic/host_read_fifo.sv
/*
 * host-to-device streaming channel top level:
 * completion receiver, read requester, reorder buffer and output FIFO
 */

`default_nettype none

module host_read_fifo import host_fifo_pkg::*; #(
   parameter int BLOCK_LOG2 = DEF_BLOCK_LOG2,   // reorder buffer blocks, log2
   parameter int DEPTH_LOG2 = DEF_DEPTH_LOG2    // output FIFO entries, log2
) (
   input  wire logic       i_clock,
   input  wire logic       i_reset,
   input  wire chan_t      i_chan,
   input  wire logic       i_cpl_valid,   // read completion beat
   input  wire logic [7:0] i_cpl_tag,
   input  wire index_t     i_cpl_index,
   input  wire data_t      i_cpl_data,
   input  wire logic       i_rr_ready,    // read request handshake
   output logic            o_rr_valid,
   output block_t          o_rr_tag,
   input  wire logic       i_read,        // output stream
   output data_t           o_read_data,
   output logic            o_read_valid,
   output logic [31:0]     o_status
);

   logic  push;          // buffer to FIFO strobe
   data_t push_data;
   logic  almost_full;   // FIFO back to buffer
   logic  drained;       // buffer back to requester, one credit per block

   cpl_if cpl_bus ();

   cpl_receiver rx_i (
      .i_clock, .i_reset, .i_chan,
      .i_cpl_valid, .i_cpl_tag, .i_cpl_index, .i_cpl_data,
      .cpl      (cpl_bus.rx),
      .o_status
   );

   read_requester #(.BLOCK_LOG2(BLOCK_LOG2)) req_i (
      .i_clock, .i_reset, .i_rr_ready,
      .i_drained (drained),
      .o_rr_valid, .o_rr_tag
   );

   reorder_buffer #(.BLOCK_LOG2(BLOCK_LOG2)) rob_i (
      .i_clock, .i_reset,
      .cpl           (cpl_bus.rob),
      .i_almost_full (almost_full),
      .o_push        (push),
      .o_push_data   (push_data),
      .o_drained     (drained)
   );

   stream_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) fifo_i (
      .i_clock, .i_reset,
      .i_push        (push),
      .i_push_data   (push_data),
      .o_almost_full (almost_full),
      .i_read, .o_read_data, .o_read_valid
   );

endmodule : host_read_fifo

`default_nettype wire

// File: verification/host_read_fifo_assert.sv
/*
 * concurrent checks on the channel for request holdoff,
 * drain against almost-full and the outstanding block window,
 * plus the bind onto the top level
 */

`default_nettype none

module host_read_fifo_assert import host_fifo_pkg::*; #(
   parameter int BLOCK_LOG2 = DEF_BLOCK_LOG2
) (
   input wire logic                  i_clock,
   input wire logic                  i_reset,
   input wire logic                  i_rr_valid,     // request strobe at the top
   input wire logic                  i_rr_ready,     // upstream takes the request
   input wire logic                  i_almost_full,  // FIFO headroom flag
   input wire logic                  i_push,         // buffer to FIFO strobe
   input wire logic [BLOCK_LOG2-1:0] i_outstanding   // requested minus drained
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_BLOCKS = 1 << BLOCK_LOG2;

   int unsigned fail_count = 0;   // number of failed properties so far
   logic        taken;            // request handed over this cycle

   assign taken = i_rr_valid && i_rr_ready;

   // after a taken request no offer may appear for three cycles
   a_holdoff : assert property (@(posedge i_clock) disable iff (i_reset)
      i_rr_valid |-> !($past(taken, 1) || $past(taken, 2) || $past(taken, 3)))
      else begin
         $error("request offered during holdoff");
         fail_count++;
      end

   // a push lands two cycles after its read and that read needed headroom
   a_no_push : assert property (@(posedge i_clock) disable iff (i_reset)
      i_push |-> !$past(i_almost_full, 2))
      else begin
         $error("push issued against almost-full");
         fail_count++;
      end

   a_window : assert property (@(posedge i_clock) disable iff (i_reset)
      i_outstanding <= BLOCK_LOG2'(NUM_BLOCKS - 2))
      else begin
         $error("outstanding block window exceeded");
         fail_count++;
      end

endmodule : host_read_fifo_assert

bind host_read_fifo host_read_fifo_assert #(.BLOCK_LOG2(BLOCK_LOG2)) assert_i (
   .i_clock       (i_clock),
   .i_reset       (i_reset),
   .i_rr_valid    (o_rr_valid),
   .i_rr_ready    (i_rr_ready),
   .i_almost_full (almost_full),
   .i_push        (push),
   .i_outstanding (req_i.outstanding)
);

`default_nettype wire

// File: verification/host_read_fifo_tb.sv
/*
 * testbench for the streaming channel with clock and reset, model memory,
 * compare tasks, output monitor, timeout and the directed tests
 */

`default_nettype none

module host_read_fifo_tb import host_fifo_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int    NUM_BLOCKS  = 1 << DEF_BLOCK_LOG2;
   localparam int    NUM_REQ     = 16;              // requests made over the whole run
   localparam int    TOTAL_BEATS = 17 * 64;         // sixteen blocks plus one foreign block
   localparam int    TIMEOUT     = 2 * TOTAL_BEATS + 2000;
   localparam chan_t MY_CHAN     = 4'h3;
   localparam chan_t OTHER_CHAN  = 4'h9;

   logic        clock;
   logic        reset;
   chan_t       chan;
   logic        cpl_valid;
   logic [7:0]  cpl_tag;
   index_t      cpl_index;
   data_t       cpl_data;
   logic        rr_ready;
   logic        rr_valid;
   block_t      rr_tag;
   logic        read_en;
   data_t       read_data;
   logic        read_valid;
   logic [31:0] status;

   integer seed = 59986;
   data_t  model [NUM_REQ][64];   // beat data by request number and beat
   data_t  exp_q [$];             // beats still owed by the FIFO in delivery order
   int     req_issued = 0;        // transfers seen on the request port
   int     cycles = 0;

   host_read_fifo #(.BLOCK_LOG2(DEF_BLOCK_LOG2), .DEPTH_LOG2(DEF_DEPTH_LOG2)) dut_i (
      .i_clock (clock), .i_reset (reset), .i_chan (chan),
      .i_cpl_valid (cpl_valid), .i_cpl_tag (cpl_tag),
      .i_cpl_index (cpl_index), .i_cpl_data (cpl_data),
      .i_rr_ready (rr_ready), .o_rr_valid (rr_valid), .o_rr_tag (rr_tag),
      .i_read (read_en), .o_read_data (read_data), .o_read_valid (read_valid),
      .o_status (status)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;   // 4 ns period
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_block(input string name, input block_t got, input block_t exp);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_status(input logic [31:0] got, input count_t blocks);
      logic [31:0] exp;
      exp = 32'(blocks) * 32'd512;   // 512 bytes per completed block
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] o_status: got 0x%h, expected 0x%h", got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   always @(posedge clock) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         fail_run("timeout: the DUT stopped delivering before the tests finished");
      end
   end

   // the bound checker counts its failed properties
   always @(negedge clock) begin
      if (dut_i.assert_i.fail_count != 0) begin
         fail_run("a concurrent assertion on the DUT failed");
      end
   end

   // every popped beat must be the next one owed so that loss or duplication shows up
   always @(posedge clock) begin
      if (!reset && read_valid && read_en) begin
         if (exp_q.size() == 0) begin
            fail_run("the FIFO delivered a beat when none was expected");
         end else begin
            check_data("o_read_data", read_data, exp_q[0]);
            void'(exp_q.pop_front());
         end
      end
   end

   // waits for each offered request and checks its tag before taking it
   task automatic request_blocks(input int n);
      repeat (n) begin
         while (!rr_valid) begin
            @(negedge clock);
         end
         check_block("o_rr_tag", rr_tag, block_t'(req_issued % NUM_BLOCKS));
         rr_ready = 1'b1;
         @(negedge clock);
         rr_ready = 1'b0;
         req_issued++;
      end
   endtask

   task automatic expect_block(input int req);
      for (int b = 0; b < 64; b++) begin
         exp_q.push_back(model[req][b]);
      end
   endtask

   // beats 0 to 62 may be shuffled while beat 63 always closes the block
   task automatic send_block(input int req, input chan_t ch, input bit shuffle);
      int order [64];
      int j;
      int tmp;
      for (int i = 0; i < 64; i++) begin
         order[i] = i;
      end
      if (shuffle) begin
         for (int i = 62; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
         end
      end
      for (int i = 0; i < 64; i++) begin
         cpl_valid = 1'b1;
         cpl_tag   = {ch, block_t'(req % NUM_BLOCKS)};
         cpl_index = index_t'(order[i]);
         cpl_data  = (ch == MY_CHAN) ? model[req][order[i]] : ~model[req][order[i]];
         @(negedge clock);
      end
      cpl_valid = 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(negedge clock);
      end
   endtask

   task automatic test_reset();
      check_flag("o_read_valid", read_valid, 1'b0);
      check_status(status, count_t'(0));
      check_flag("o_rr_valid", rr_valid, 1'b1);
      check_block("o_rr_tag", rr_tag, block_t'(0));
   endtask

   task automatic test_single_block();
      request_blocks(1);
      expect_block(0);
      send_block(0, MY_CHAN, 1'b0);
      wait_drained();
      check_status(status, count_t'(1));
   endtask

   task automatic test_out_of_order();
      request_blocks(3);
      expect_block(1);
      expect_block(2);
      expect_block(3);
      send_block(3, MY_CHAN, 1'b1);   // newest block first
      send_block(1, MY_CHAN, 1'b1);
      send_block(2, MY_CHAN, 1'b1);
      wait_drained();
      check_status(status, count_t'(4));
   endtask

   task automatic test_other_channel();
      request_blocks(1);
      send_block(4, OTHER_CHAN, 1'b0);   // same slot with the wrong channel nibble
      repeat (20) begin
         @(negedge clock);
         check_flag("o_read_valid", read_valid, 1'b0);
      end
      check_status(status, count_t'(4));
      expect_block(4);
      send_block(4, MY_CHAN, 1'b0);
      wait_drained();
      check_status(status, count_t'(5));
   endtask

   task automatic test_request_window();
      request_blocks(NUM_BLOCKS - 2);
      rr_ready = 1'b1;   // any further offer would be taken at once
      repeat (12) begin
         @(negedge clock);
         check_flag("o_rr_valid", rr_valid, 1'b0);
      end
      rr_ready = 1'b0;
      for (int r = 5; r < 11; r++) begin
         expect_block(r);
      end
      for (int r = 10; r >= 5; r--) begin
         send_block(r, MY_CHAN, 1'b1);
      end
      wait_drained();
      request_blocks(1);   // the window has reopened and the tag continues the sequence
      expect_block(11);
      send_block(11, MY_CHAN, 1'b0);
      wait_drained();
      check_status(status, count_t'(12));
   endtask

   task automatic test_backpressure();
      read_en = 1'b0;
      request_blocks(4);
      for (int r = 12; r < 16; r++) begin
         expect_block(r);
      end
      send_block(13, MY_CHAN, 1'b1);
      send_block(12, MY_CHAN, 1'b1);
      send_block(15, MY_CHAN, 1'b1);
      send_block(14, MY_CHAN, 1'b1);
      repeat (32) begin
         @(negedge clock);
      end
      check_flag("o_read_valid", read_valid, 1'b1);   // FIFO is holding beats
      read_en = 1'b1;
      wait_drained();
      repeat (8) begin
         @(negedge clock);
         check_flag("o_read_valid", read_valid, 1'b0);
      end
      check_status(status, count_t'(16));
   endtask

   initial begin
      reset     = 1'b1;
      chan      = MY_CHAN;
      cpl_valid = 1'b0;
      cpl_tag   = '0;
      cpl_index = '0;
      cpl_data  = '0;
      rr_ready  = 1'b0;
      read_en   = 1'b1;
      for (int r = 0; r < NUM_REQ; r++) begin
         for (int b = 0; b < 64; b++) begin
            model[r][b] = {$random(seed), $random(seed)};
         end
      end
      repeat (8) begin
         @(negedge clock);
      end
      reset = 1'b0;
      test_reset();
      test_single_block();
      test_out_of_order();
      test_other_channel();
      test_request_window();
      test_backpressure();
      if (exp_q.size() == 0 && dut_i.assert_i.fail_count == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         fail_run("beats were still owed or an assertion failed when the tests ended");
      end
   end

endmodule : host_read_fifo_tb

`default_nettype wire

// File: vlog.f
logic/host_fifo_pkg.sv
logic/cpl_if.sv
logic/cpl_receiver.sv
logic/read_requester.sv
logic/reorder_buffer.sv
logic/stream_fifo.sv
logic/host_read_fifo.sv
verification/host_read_fifo_assert.sv
verification/host_read_fifo_tb.sv
